//--- rtl/cpu_bus_pkg.sv
// Bus widths and instruction queue sizing shared by the fetch, queue, execute and bus blocks.
// Import it wherever a bus-facing width is needed.
package cpu_bus_pkg;

	// ########################################
	// Memory bus
	// ########################################

	localparam int DATA_BITS = 16;         // Data word width.
	localparam int ADDRESS_BITS = 16;      // Word address width.

	// ########################################
	// Port bus
	// ########################################

	localparam int PORT_ADDRESS_BITS = 8;  // Port address width.

	// ########################################
	// Instruction queue
	// ########################################

	localparam int IQ_DEPTH = 4;

	// Pointer and occupancy widths follow from the depth.
	localparam int IQ_PTR_BITS = $clog2(IQ_DEPTH);
	localparam int IQ_COUNT_BITS = $clog2(IQ_DEPTH + 1);

endpackage

//--- rtl/cpu_isa_pkg.sv
// Instruction set of the core, with opcodes and the two instruction word formats.
// The decoder and the test program both build on these definitions.
package cpu_isa_pkg;

	localparam int REGISTER_BITS = 4;  // 16 registers.

	// Opcode sits in the top nibble of every instruction word.
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_ADDI = 4'h4,
		OP_LDI  = 4'h5,
		OP_LD   = 4'h6,
		OP_ST   = 4'h7,
		OP_IN   = 4'h8,
		OP_OUT  = 4'h9,
		OP_HLT  = 4'hf
	} opcode_e;

	// Register format, used by ALU ops, LD and ST.
	typedef struct packed {
		opcode_e op;
		logic [REGISTER_BITS-1:0] rd;
		logic [REGISTER_BITS-1:0] ra;
		logic [REGISTER_BITS-1:0] rb;
	} instr_r_t;

	// Immediate format, used by ADDI, LDI, IN and OUT.
	typedef struct packed {
		opcode_e op;
		logic [REGISTER_BITS-1:0] rd;
		logic [7:0] imm;
	} instr_i_t;

	// One 16-bit word seen through either format.
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

endpackage

//--- rtl/cpu_ifs.sv
// Internal handshake bundles: memory requests from fetch and execute,
// and the instruction stream into and out of the queue.
`timescale 1ns/1ps

// ########################################
// Memory request, valid/ready
// ########################################

interface mem_req_if import cpu_bus_pkg::*; ();
	logic [ADDRESS_BITS-1:0] addr;
	logic [DATA_BITS-1:0] wdata;
	logic wr;
	logic valid;
	logic ready;
	logic [DATA_BITS-1:0] rdata;  // Valid in the handshake cycle.

	modport requester (output addr, wdata, wr, valid, input ready, rdata);
	modport completer (input addr, wdata, wr, valid, output ready, rdata);
endinterface

// ########################################
// Instruction stream
// ########################################

interface iq_if import cpu_bus_pkg::*; ();
	logic [DATA_BITS-1:0] data;
	logic valid;
	logic ready;

	// Producer offers a word, consumer takes it when both are high.
	modport producer (output data, valid, input ready);
	modport consumer (input data, valid, output ready);
endinterface

//--- rtl/cpu_fetch.sv
// Sequential instruction fetch from address 0 upwards, one read in flight at a time.
// Each fetched word waits in a holding register until the queue takes it.
`timescale 1ns/1ps

module cpu_fetch import cpu_bus_pkg::*; (
	input logic CLK,
	input logic rst_n,
	mem_req_if.requester mem,
	iq_if.producer iq
);

	logic [ADDRESS_BITS-1:0] pc;
	logic req_active;                 // Read outstanding on the bus.
	logic hold_valid;                 // Fetched word not yet pushed.
	logic [DATA_BITS-1:0] hold_data;
	logic mem_done;
	logic push_done;

	assign mem_done = mem.valid && mem.ready;
	assign push_done = iq.valid && iq.ready;

	// Reads only, address straight from the PC.
	assign mem.addr = pc;
	assign mem.wdata = '0;
	assign mem.wr = 1'b0;
	assign mem.valid = req_active;

	assign iq.data = hold_data;
	assign iq.valid = hold_valid;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
			req_active <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			if (mem_done) begin
				req_active <= 1'b0;
				hold_valid <= 1'b1;
				pc <= pc + 1'b1;
			end else if (!req_active && !hold_valid && iq.ready) begin
				req_active <= 1'b1;  // Room downstream, start next read.
			end
			if (push_done)
				hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (mem_done)
			hold_data <= mem.rdata;  // Payload, no reset.
	end

	// A stalled read keeps its request and address.
	a_req_stable: assert property (@(posedge CLK) disable iff (!rst_n)
		mem.valid && !mem.ready |=> mem.valid && $stable(mem.addr));

endmodule

//--- rtl/cpu_instruction_queue.sv
// Small circular FIFO between fetch and execute.
// A word pushed in one cycle shows at the head in the next.
`timescale 1ns/1ps

module cpu_instruction_queue import cpu_bus_pkg::*; (
	input logic CLK,
	input logic rst_n,
	iq_if.consumer push,
	iq_if.producer pop
);

	logic [DATA_BITS-1:0] entries [IQ_DEPTH];
	logic [IQ_PTR_BITS-1:0] wr_ptr;
	logic [IQ_PTR_BITS-1:0] rd_ptr;
	logic [IQ_COUNT_BITS-1:0] count;
	logic push_fire;
	logic pop_fire;

	assign push.ready = (count != IQ_COUNT_BITS'(IQ_DEPTH));  // Not full.
	assign pop.valid = (count != '0);
	assign pop.data = entries[rd_ptr];

	assign push_fire = push.valid && push.ready;
	assign pop_fire = pop.valid && pop.ready;

	// ########################################
	// Pointers and occupancy
	// ########################################

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_fire)
				wr_ptr <= (wr_ptr == IQ_PTR_BITS'(IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_fire)
				rd_ptr <= (rd_ptr == IQ_PTR_BITS'(IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push_fire, pop_fire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;  // Both or neither.
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (push_fire)
			entries[wr_ptr] <= push.data;
	end

	// Equal pointers mean an empty or a full buffer, and the count tells which.
	a_no_overflow: assert property (@(posedge CLK) disable iff (!rst_n)
		push_fire |-> (wr_ptr != rd_ptr) || (count == '0));
	a_no_underflow: assert property (@(posedge CLK) disable iff (!rst_n)
		pop_fire |-> (wr_ptr != rd_ptr) || (count == IQ_COUNT_BITS'(IQ_DEPTH)));

endmodule

//--- rtl/cpu_execute.sv
// Execute stage that decodes the queue head, runs it against the register file
// and issues any load, store or port access. HLT stops it until reset.
`timescale 1ns/1ps

module cpu_execute import cpu_bus_pkg::*, cpu_isa_pkg::*; (
	input logic CLK,
	input logic rst_n,
	iq_if.consumer iq,
	mem_req_if.requester mem,
	output logic [PORT_ADDRESS_BITS-1:0] port_address,
	output logic [DATA_BITS-1:0] port_out,
	output logic port_wr,
	output logic port_rd,
	input logic [DATA_BITS-1:0] port_in
);

	logic [DATA_BITS-1:0] regs [2**REGISTER_BITS];
	logic halted;
	instr_u instr;
	logic active;       // Head is valid and we are not halted.
	logic is_mem;
	logic fire;         // Head instruction completes this cycle.
	logic [DATA_BITS-1:0] val_rd;
	logic [DATA_BITS-1:0] val_ra;
	logic [DATA_BITS-1:0] val_rb;
	logic [DATA_BITS-1:0] result;
	logic wb_en;

	assign instr = iq.data;
	assign active = iq.valid && !halted;
	assign is_mem = (instr.r.op == OP_LD) || (instr.r.op == OP_ST);

	// Register reads are asynchronous.
	assign val_rd = regs[instr.r.rd];
	assign val_ra = regs[instr.r.ra];
	assign val_rb = regs[instr.r.rb];

	// ########################################
	// Load/store and port access
	// ########################################

	assign mem.valid = active && is_mem;  // Held until ready while the head stays put.
	assign mem.wr = (instr.r.op == OP_ST);
	assign mem.addr = val_ra;
	assign mem.wdata = val_rb;

	assign fire = active && (!is_mem || mem.ready);
	assign iq.ready = fire;

	assign port_address = instr.i.imm;
	assign port_out = val_rd;
	assign port_wr = fire && (instr.i.op == OP_OUT);
	assign port_rd = fire && (instr.i.op == OP_IN);

	// ########################################
	// Result select and writeback
	// ########################################

	always_comb begin
		result = '0;
		wb_en = 1'b1;
		case (instr.r.op)
			OP_ADD:  result = val_ra + val_rb;
			OP_SUB:  result = val_ra - val_rb;
			OP_AND:  result = val_ra & val_rb;
			OP_OR:   result = val_ra | val_rb;
			OP_ADDI: result = val_rd + DATA_BITS'(instr.i.imm);
			OP_LDI:  result = DATA_BITS'(instr.i.imm);  // Zero-extended.
			OP_LD:   result = mem.rdata;
			OP_IN:   result = port_in;
			default: wb_en = 1'b0;  // ST, OUT, HLT and unused codes.
		endcase
	end

	always_ff @(posedge CLK) begin
		if (fire && wb_en)
			regs[instr.r.rd] <= result;
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			halted <= 1'b0;
		else if (fire && (instr.r.op == OP_HLT))
			halted <= 1'b1;
	end

	a_port_excl: assert property (@(posedge CLK) disable iff (!rst_n)
		!(port_wr && port_rd));

endmodule

//--- rtl/cpu_memory_interface.sv
// Shares the external memory bus between instruction fetch and data access.
// Data wins when the bus is free, and a granted request keeps it until ready.
`timescale 1ns/1ps

module cpu_memory_interface import cpu_bus_pkg::*; (
	input logic CLK,
	input logic rst_n,
	mem_req_if.completer fetch_req,
	mem_req_if.completer data_req,
	output logic [ADDRESS_BITS-1:0] memory_address,
	output logic [DATA_BITS-1:0] memory_out,
	output logic memory_wr,
	output logic memory_valid,
	input logic [DATA_BITS-1:0] memory_in,
	input logic memory_ready
);

	logic locked;      // Bus held by a stalled transfer.
	logic grant_data;  // Owner while locked, 1 for data.
	logic data_sel;

	assign data_sel = locked ? grant_data : data_req.valid;

	// Forward the selected request combinationally.
	assign memory_address = data_sel ? data_req.addr : fetch_req.addr;
	assign memory_out = data_sel ? data_req.wdata : fetch_req.wdata;
	assign memory_wr = data_sel ? data_req.wr : fetch_req.wr;
	assign memory_valid = data_sel ? data_req.valid : fetch_req.valid;

	// Ready and read data go only to the owner.
	assign data_req.ready = data_sel && memory_ready;
	assign fetch_req.ready = !data_sel && memory_ready;
	assign data_req.rdata = data_sel ? memory_in : '0;
	assign fetch_req.rdata = data_sel ? '0 : memory_in;

	// ########################################
	// Grant lock
	// ########################################

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			locked <= 1'b0;
			grant_data <= 1'b0;
		end else if (memory_valid && memory_ready) begin
			locked <= 1'b0;            // Transfer done, rearbitrate.
		end else if (memory_valid && !locked) begin
			locked <= 1'b1;
			grant_data <= data_sel;
		end
	end

	a_grant_held: assert property (@(posedge CLK) disable iff (!rst_n)
		memory_valid && !memory_ready |=> $stable(data_sel) && memory_valid);

endmodule

//--- rtl/cpu_top.sv
// Top level of the 16-bit core: fetch, instruction queue, execute and memory arbiter.
// Exposes the word-addressed memory bus and the 8-bit port bus.
`timescale 1ns/1ps

module cpu_top import cpu_bus_pkg::*; (
	input logic CLK,
	input logic rst_n,

	output logic [ADDRESS_BITS-1:0] memory_address,
	input logic [DATA_BITS-1:0] memory_in,
	output logic [DATA_BITS-1:0] memory_out,
	output logic memory_valid,  // Memory request.
	output logic memory_wr,     // Memory write.
	input logic memory_ready,

	output logic [PORT_ADDRESS_BITS-1:0] port_address,
	input logic [DATA_BITS-1:0] port_in,
	output logic [DATA_BITS-1:0] port_out,
	output logic port_rd,
	output logic port_wr
);

	mem_req_if fetch_mem ();
	mem_req_if data_mem ();
	iq_if iq_push ();
	iq_if iq_pop ();

	cpu_fetch fetch0 (.CLK(CLK), .rst_n(rst_n), .mem(fetch_mem), .iq(iq_push));

	cpu_instruction_queue iq0 (.CLK(CLK), .rst_n(rst_n), .push(iq_push), .pop(iq_pop));

	cpu_execute exec0 (
		.CLK(CLK),
		.rst_n(rst_n),
		.iq(iq_pop),
		.mem(data_mem),
		.port_address(port_address),
		.port_out(port_out),
		.port_wr(port_wr),
		.port_rd(port_rd),
		.port_in(port_in)
	);

	cpu_memory_interface mem0 (
		.CLK(CLK),
		.rst_n(rst_n),
		.fetch_req(fetch_mem),
		.data_req(data_mem),
		.memory_address(memory_address),
		.memory_out(memory_out),
		.memory_wr(memory_wr),
		.memory_valid(memory_valid),
		.memory_in(memory_in),
		.memory_ready(memory_ready)
	);

endmodule

//--- verif/tb_memory_model.sv
// Behavioural word memory for the testbench, preloaded with the test program.
// Answers each bus request after a random wait of 0 to 3 cycles.
`timescale 1ns/1ps

module tb_memory_model import cpu_bus_pkg::*, cpu_isa_pkg::*; (
	input logic CLK,
	input logic rst_n,
	input logic [ADDRESS_BITS-1:0] memory_address,
	input logic [DATA_BITS-1:0] memory_out,
	input logic memory_wr,
	input logic memory_valid,
	output logic [DATA_BITS-1:0] memory_in,
	output logic memory_ready
);

	localparam int MEM_WORDS = 2**ADDRESS_BITS;

	logic [DATA_BITS-1:0] mem [MEM_WORDS];
	int unsigned wait_left;  // Cycles before ready goes high.
	logic busy;              // A request is being served.
	logic fired;

	function automatic logic [DATA_BITS-1:0] r_word(opcode_e op, int rd, int ra, int rb);
		instr_u w;
		w.r.op = op;
		w.r.rd = REGISTER_BITS'(rd);
		w.r.ra = REGISTER_BITS'(ra);
		w.r.rb = REGISTER_BITS'(rb);
		return w;
	endfunction

	function automatic logic [DATA_BITS-1:0] i_word(opcode_e op, int rd, logic [7:0] imm);
		instr_u w;
		w.i.op = op;
		w.i.rd = REGISTER_BITS'(rd);
		w.i.imm = imm;
		return w;
	endfunction

	// ########################################
	// Test program
	// ########################################

	task automatic load_program();
		mem[0] = i_word(OP_LDI, 1, 8'h12);
		mem[1] = i_word(OP_LDI, 2, 8'h34);
		mem[2] = r_word(OP_ADD, 3, 1, 2);
		mem[3] = r_word(OP_SUB, 4, 2, 1);
		mem[4] = r_word(OP_AND, 5, 1, 2);
		mem[5] = i_word(OP_OUT, 3, 8'h10);
		mem[6] = i_word(OP_OUT, 4, 8'h11);
		mem[7] = r_word(OP_OR, 6, 5, 4);
		mem[8] = i_word(OP_ADDI, 6, 8'hf0);
		mem[9] = i_word(OP_OUT, 6, 8'h12);
		mem[10] = i_word(OP_LDI, 7, 8'h90);  // Data area pointer.
		mem[11] = r_word(OP_ST, 0, 7, 6);
		mem[12] = r_word(OP_LD, 8, 7, 7);
		mem[13] = i_word(OP_OUT, 8, 8'h20);
		mem[14] = i_word(OP_IN, 9, 8'h30);
		mem[15] = r_word(OP_ADD, 10, 9, 3);
		mem[16] = i_word(OP_OUT, 10, 8'h21);
		mem[17] = i_word(OP_LDI, 11, 8'ha5);
		mem[18] = r_word(OP_LD, 12, 11, 11);  // Reads the fill pattern.
		mem[19] = i_word(OP_OUT, 12, 8'h22);
		mem[20] = i_word(OP_HLT, 0, 8'h00);
		mem[21] = i_word(OP_OUT, 1, 8'h7f);   // Must never run.
		mem[22] = r_word(OP_ST, 0, 7, 1);
	endtask

	initial begin
		void'($urandom(24130));
		memory_in = '0;
		memory_ready = 1'b0;
		busy = 1'b0;
		wait_left = 0;
		for (int a = 0; a < MEM_WORDS; a++)
			mem[a] = DATA_BITS'(a) ^ 16'hc35a;
		load_program();
		forever begin
			@(negedge CLK);
			fired = memory_valid && memory_ready;  // Transfer at the coming edge.
			if (fired && memory_wr)
				mem[memory_address] = memory_out;
			@(posedge CLK);
			#1;
			if (!rst_n || fired) begin
				memory_ready = 1'b0;
				busy = 1'b0;
			end
			if (rst_n && memory_valid && !busy) begin
				busy = 1'b1;
				wait_left = $urandom_range(3, 0);
			end
			if (busy && wait_left == 0) begin
				memory_ready = 1'b1;
				memory_in = mem[memory_address];
			end else if (busy) begin
				wait_left--;
			end
		end
	end

endmodule

//--- verif/tb_cpu_top.sv
// Testbench for the core. It runs the program image through an ISA reference model
// and checks bus and port traffic against it with assertions.
`timescale 1ns/1ps

module tb_cpu_top import cpu_bus_pkg::*, cpu_isa_pkg::*;;

	localparam logic [ADDRESS_BITS-1:0] DATA_BASE = 16'h0080;  // Fetches stay below.
	localparam int STEP_LIMIT = 64;
	localparam int WAIT_CYCLES = 2000;
	localparam int QUIET_CYCLES = 40;

	logic CLK;
	logic rst_n;
	logic [ADDRESS_BITS-1:0] memory_address;
	logic [DATA_BITS-1:0] memory_in;
	logic [DATA_BITS-1:0] memory_out;
	logic memory_valid;
	logic memory_wr;
	logic memory_ready;
	logic [PORT_ADDRESS_BITS-1:0] port_address;
	logic [DATA_BITS-1:0] port_in;
	logic [DATA_BITS-1:0] port_out;
	logic port_rd;
	logic port_wr;

	logic [23:0] out_q [$];  // {port, data}
	logic [31:0] st_q [$];   // {address, data}
	logic [7:0] in_q [$];
	logic [23:0] exp_out;
	logic [31:0] exp_st;
	logic [ADDRESS_BITS-1:0] next_fetch;
	logic quiet;             // Program has halted.
	int errors;
	int timeouts;
	int model_outs;
	int seen_outs;
	int cycles;

	cpu_top DUT (.*);

	tb_memory_model memory (.*);

	always #50 CLK = ~CLK;

	// Value the port bus returns for each port address.
	function automatic logic [DATA_BITS-1:0] port_stimulus(logic [7:0] addr);
		return {addr ^ 8'ha7, addr};
	endfunction

	task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
		errors++;
		$display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
	endtask

	task automatic report_problem(string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	// ########################################
	// ISA reference model
	// ########################################

	task automatic run_reference();
		logic [DATA_BITS-1:0] regs [2**REGISTER_BITS];
		logic [DATA_BITS-1:0] dmem [logic [ADDRESS_BITS-1:0]];
		instr_u w;
		logic [DATA_BITS-1:0] a;
		logic [DATA_BITS-1:0] b;
		logic [DATA_BITS-1:0] d;
		int pc;
		pc = 0;
		for (int r = 0; r < 2**REGISTER_BITS; r++)
			regs[r] = '0;
		for (int step = 0; step < STEP_LIMIT; step++) begin
			w = memory.mem[pc];
			pc++;
			a = regs[w.r.ra];
			b = regs[w.r.rb];
			d = regs[w.i.rd];
			case (w.r.op)
				OP_ADD:  regs[w.r.rd] = a + b;
				OP_SUB:  regs[w.r.rd] = a - b;
				OP_AND:  regs[w.r.rd] = a & b;
				OP_OR:   regs[w.r.rd] = a | b;
				OP_ADDI: regs[w.i.rd] = d + {8'h00, w.i.imm};
				OP_LDI:  regs[w.i.rd] = {8'h00, w.i.imm};
				OP_LD:   regs[w.r.rd] = dmem.exists(a) ? dmem[a] : memory.mem[a];
				OP_ST: begin
					dmem[a] = b;
					st_q.push_back({a, b});
				end
				OP_IN: begin
					in_q.push_back(w.i.imm);
					regs[w.i.rd] = port_stimulus(w.i.imm);
				end
				OP_OUT: begin
					out_q.push_back({w.i.imm, d});
					model_outs++;
				end
				OP_HLT:  return;
				default: ;
			endcase
		end
		report_problem("reference model never reached HLT");
	endtask

	// ########################################
	// Checks
	// ########################################

	a_reset_idle: assert property (@(posedge CLK) (!rst_n || $rose(rst_n)) |->
		!memory_valid && !memory_wr && !port_wr && !port_rd)
		else report_problem("bus or port strobe active in or right after reset");
	a_bus_stable: assert property (@(posedge CLK) disable iff (!rst_n)
		memory_valid && !memory_ready |=> memory_valid && $stable(memory_address)
		&& $stable(memory_wr) && $stable(memory_out))
		else report_problem("memory request changed before memory_ready");
	a_halt_quiet: assert property (@(posedge CLK) quiet |->
		!port_wr && !port_rd && !(memory_valid && memory_wr))
		else report_problem("port or store activity after HLT");

	// Outputs are stable mid-cycle, so events are compared at the falling edge.
	always @(negedge CLK) begin
		if (rst_n && port_wr) begin
			seen_outs++;
			if (out_q.size() == 0) begin
				report_problem("port write with no OUT left in the reference model");
			end else begin
				exp_out = out_q.pop_front();
				assert (port_address == exp_out[23:16])
					else report_mismatch("port_address", exp_out[23:16], port_address);
				assert (port_out == exp_out[15:0])
					else report_mismatch("port_out", exp_out[15:0], port_out);
			end
		end
		if (rst_n && port_rd) begin
			if (in_q.size() == 0)
				report_problem("port read with no IN left in the reference model");
			else
				assert (port_address == in_q[0])
					else report_mismatch("port_address", in_q[0], port_address);
			if (in_q.size() != 0)
				void'(in_q.pop_front());
		end
		if (rst_n && memory_valid && memory_ready && memory_wr) begin
			if (st_q.size() == 0) begin
				report_problem("memory write with no ST left in the reference model");
			end else begin
				exp_st = st_q.pop_front();
				assert (memory_address == exp_st[31:16])
					else report_mismatch("memory_address", exp_st[31:16], memory_address);
				assert (memory_out == exp_st[15:0])
					else report_mismatch("memory_out", exp_st[15:0], memory_out);
			end
		end
		if (rst_n && memory_valid && memory_ready && !memory_wr && memory_address < DATA_BASE) begin
			assert (memory_address == next_fetch)
				else report_mismatch("memory_address", next_fetch, memory_address);
			next_fetch = next_fetch + 1'b1;
		end
	end

	// Port input follows the port address shortly after each edge.
	always @(posedge CLK) begin
		#1;
		port_in = port_stimulus(port_address);
	end

	initial begin
		CLK = 1'b0;
		rst_n = 1'b0;
		port_in = '0;
		next_fetch = '0;
		quiet = 1'b0;
		errors = 0;
		timeouts = 0;
		model_outs = 0;
		seen_outs = 0;
		repeat (2) @(posedge CLK);
		run_reference();
		#1 rst_n = 1'b1;

		cycles = 0;
		while ((out_q.size() + st_q.size() + in_q.size()) != 0 && cycles < WAIT_CYCLES) begin
			@(posedge CLK);
			cycles++;
		end
		if ((out_q.size() + st_q.size() + in_q.size()) != 0) begin
			timeouts++;
			$display("Timeout: the core did not produce all expected port and store events");
		end

		quiet = 1'b1;
		cycles = 0;
		while (cycles < QUIET_CYCLES) begin
			@(posedge CLK);
			cycles++;
		end
		assert (seen_outs == model_outs)
			else report_mismatch("OUT count", model_outs, seen_outs);

		$display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- cpu_top.f
rtl/cpu_bus_pkg.sv
rtl/cpu_isa_pkg.sv
rtl/cpu_ifs.sv
rtl/cpu_fetch.sv
rtl/cpu_instruction_queue.sv
rtl/cpu_execute.sv
rtl/cpu_memory_interface.sv
rtl/cpu_top.sv
verif/tb_memory_model.sv
verif/tb_cpu_top.sv

//--- Bender.yml
package:
  name: cpu_top

sources:
  - rtl/cpu_bus_pkg.sv
  - rtl/cpu_isa_pkg.sv
  - rtl/cpu_ifs.sv
  - rtl/cpu_fetch.sv
  - rtl/cpu_instruction_queue.sv
  - rtl/cpu_execute.sv
  - rtl/cpu_memory_interface.sv
  - rtl/cpu_top.sv
  - target: test
    files:
      - verif/tb_memory_model.sv
      - verif/tb_cpu_top.sv
